//--- design/tlb_hit_merge.sv
// tlb hit merger
// picks the lowest hitting way, builds the physical address,
// rights and fault, and registers the lookup result

`timescale 1ns/10ps

`include "tlb_params.svh"

module tlb_hit_merge (
	input  logic                                   clk_g,
	input  logic                                   rst_i,
	// request, delayed one cycle to line up with the way compare
	input  logic                                   xlat_d_i,
	input  logic [`TLB_OFS_W-1:0]                  ofs_d_i,
	input  logic                                   we_d_i,
	// per-way compare results
	input  logic [`TLB_ASSOC-1:0]                  hit_i,
	input  logic [`TLB_ASSOC-1:0][`TLB_PPN_W-1:0]  ppn_i,
	input  logic [`TLB_ASSOC-1:0][2:0]             rwx_i,
	input  logic [`TLB_ASSOC-1:0]                  m_i,
	// lookup result
	output logic                                   valid_o,
	output logic                                   hit_o,
	output logic                                   miss_o,
	output tlb_pkg::way_idx_t                      hit_way_o,
	output logic [`TLB_ADR_W-1:0]                  padr_o,
	output logic [3:0]                             acr_o,
	output logic                                   fault_o
);

	tlb_pkg::way_idx_t sel;
	logic              any_hit;
	logic [2:0]        sel_rwx;
	logic              need_miss;

	// ==============================
	// way select
	// ==============================
	// scan down so the lowest hitting way is left in sel
	always_comb begin
		sel = '0;
		for (int i = `TLB_ASSOC-1; i >= 0; i--) begin
			if (hit_i[i])
				sel = tlb_pkg::way_idx_t'(i);
		end
	end

	assign any_hit = |hit_i;
	assign sel_rwx = rwx_i[sel];

	// write lookups need w, read lookups need r
	assign need_miss = we_d_i ? ~sel_rwx[1] : ~sel_rwx[2];

	// ==============================
	// result register
	// ==============================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			valid_o   <= 1'b0;
			hit_o     <= 1'b0;
			miss_o    <= 1'b0;
			hit_way_o <= '0;
			padr_o    <= '0;
			acr_o     <= '0;
			fault_o   <= 1'b0;
		end else begin
			valid_o   <= xlat_d_i;
			hit_o     <= xlat_d_i && any_hit;
			miss_o    <= xlat_d_i && !any_hit;
			hit_way_o <= sel;
			padr_o    <= {ppn_i[sel], ofs_d_i};
			// m as read, before this lookup's own dirty update
			acr_o     <= {m_i[sel], sel_rwx};
			fault_o   <= xlat_d_i && any_hit && need_miss;
		end
	end

endmodule

//--- design/tlb_params.svh
// tlb parameters
// geometry and field widths of the set-associative tlb
// the set index sits right above the page offset, the tag takes the rest

`ifndef TLB_PARAMS_SVH
`define TLB_PARAMS_SVH

// ==============================
// geometry
// ==============================
`define TLB_ASSOC   4
`define TLB_SETS    32
`define TLB_SET_W   5

// ==============================
// field widths
// ==============================
`define TLB_ADR_W   32
`define TLB_OFS_W   12
`define TLB_TAG_W   15
`define TLB_PPN_W   20
`define TLB_ASID_W  8

`endif

//--- design/tlb_pkg.sv
// tlb package
// entry layout, way index and update controller states

`include "tlb_params.svh"

package tlb_pkg;

	// ==============================
	// tlb entry
	// ==============================
	// rwx bit 2 is read, bit 1 is write, bit 0 is execute
	// m is the dirty bit, set in place by a write lookup that hits
	typedef struct packed {
		logic                   v;
		logic                   g;
		logic                   m;
		logic [2:0]             rwx;
		logic [`TLB_ASID_W-1:0] asid;
		logic [`TLB_TAG_W-1:0]  tag;
		logic [`TLB_PPN_W-1:0]  ppn;
	} tlb_entry_t;

	// way number, wide enough for TLB_ASSOC ways
	typedef logic [1:0] way_idx_t;

	// update controller
	// sweep clears every set after reset, run takes software writes
	typedef enum logic {
		ST_SWEEP = 1'b0,
		ST_RUN   = 1'b1
	} ctrl_state_t;

endpackage

//--- design/tlb_top.sv
// tlb top level
// set-associative tlb: update controller, TLB_ASSOC ways and hit merger
// lookup result appears two cycles after the request edge

`timescale 1ns/10ps

`include "tlb_params.svh"

module tlb_top (
	input  logic                   clk_g,
	input  logic                   rst_i,
	// lookup request
	input  logic                   xlat_i,
	input  logic [`TLB_ADR_W-1:0]  vadr_i,
	input  logic [`TLB_ASID_W-1:0] asid_i,
	input  logic                   we_i,
	// software write
	input  logic                   wr_i,
	input  logic                   wr_rr_i,
	input  tlb_pkg::way_idx_t      wr_way_i,
	input  logic [`TLB_SET_W-1:0]  wr_set_i,
	input  logic                   wr_v_i,
	input  logic                   wr_g_i,
	input  logic [2:0]             wr_rwx_i,
	input  logic [`TLB_ASID_W-1:0] wr_asid_i,
	input  logic [`TLB_TAG_W-1:0]  wr_tag_i,
	input  logic [`TLB_PPN_W-1:0]  wr_ppn_i,
	// status and lookup result
	output logic                   rdy_o,
	output logic                   valid_o,
	output logic                   hit_o,
	output logic                   miss_o,
	output tlb_pkg::way_idx_t      hit_way_o,
	output logic [`TLB_ADR_W-1:0]  padr_o,
	output logic [3:0]             acr_o,
	output logic                   fault_o
);

	// controller broadcast
	logic                   wr_en;
	logic [`TLB_SET_W-1:0]  wr_set;
	logic [`TLB_ASSOC-1:0]  wr_way;
	logic                   wr_v;
	logic                   wr_g;
	logic [2:0]             wr_rwx;
	logic [`TLB_ASID_W-1:0] wr_asid;
	logic [`TLB_TAG_W-1:0]  wr_tag;
	logic [`TLB_PPN_W-1:0]  wr_ppn;

	// way results
	logic [`TLB_ASSOC-1:0]                 way_hit;
	logic [`TLB_ASSOC-1:0][`TLB_PPN_W-1:0] way_ppn;
	logic [`TLB_ASSOC-1:0][2:0]            way_rwx;
	logic [`TLB_ASSOC-1:0]                 way_m;

	// request delayed to the compare cycle
	logic                  xlat_d;
	logic [`TLB_OFS_W-1:0] ofs_d;
	logic                  we_d;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			xlat_d <= 1'b0;
		else
			xlat_d <= xlat_i;
	end

	always_ff @(posedge clk_g) begin
		ofs_d <= vadr_i[`TLB_OFS_W-1:0];
		we_d  <= we_i;
	end

	tlb_update_ctrl u_ctrl (
		.clk_g, .rst_i, .wr_i, .wr_rr_i, .wr_way_i, .wr_set_i,
		.wr_v_i, .wr_g_i, .wr_rwx_i, .wr_asid_i, .wr_tag_i, .wr_ppn_i,
		.rdy_o, .wr_en_o(wr_en), .wr_set_o(wr_set), .wr_way_o(wr_way),
		.wr_v_o(wr_v), .wr_g_o(wr_g), .wr_rwx_o(wr_rwx),
		.wr_asid_o(wr_asid), .wr_tag_o(wr_tag), .wr_ppn_o(wr_ppn)
	);

	// ==============================
	// ways
	// ==============================
	for (genvar i = 0; i < `TLB_ASSOC; i++) begin : g_way
		tlb_way u_way (
			.clk_g, .rst_i, .wr_en_i(wr_en), .wr_sel_i(wr_way[i]), .wr_set_i(wr_set),
			.wr_v_i(wr_v), .wr_g_i(wr_g), .wr_rwx_i(wr_rwx), .wr_asid_i(wr_asid),
			.wr_tag_i(wr_tag), .wr_ppn_i(wr_ppn), .xlat_i, .vadr_i, .asid_i, .we_i,
			.hit_o(way_hit[i]), .ppn_o(way_ppn[i]), .rwx_o(way_rwx[i]), .m_o(way_m[i])
		);
	end

	tlb_hit_merge u_merge (
		.clk_g, .rst_i, .xlat_d_i(xlat_d), .ofs_d_i(ofs_d), .we_d_i(we_d),
		.hit_i(way_hit), .ppn_i(way_ppn), .rwx_i(way_rwx), .m_i(way_m),
		.valid_o, .hit_o, .miss_o, .hit_way_o, .padr_o, .acr_o, .fault_o
	);

endmodule

//--- design/tlb_update_ctrl.sv
// tlb update controller
// sweeps all sets invalid after reset, then registers software writes
// and broadcasts them to the ways with a one-hot way select

`timescale 1ns/10ps

`include "tlb_params.svh"

module tlb_update_ctrl (
	input  logic                   clk_g,
	input  logic                   rst_i,
	// software write strobe and entry
	input  logic                   wr_i,
	input  logic                   wr_rr_i,
	input  tlb_pkg::way_idx_t      wr_way_i,
	input  logic [`TLB_SET_W-1:0]  wr_set_i,
	input  logic                   wr_v_i,
	input  logic                   wr_g_i,
	input  logic [2:0]             wr_rwx_i,
	input  logic [`TLB_ASID_W-1:0] wr_asid_i,
	input  logic [`TLB_TAG_W-1:0]  wr_tag_i,
	input  logic [`TLB_PPN_W-1:0]  wr_ppn_i,
	output logic                   rdy_o,
	// broadcast to the ways
	output logic                   wr_en_o,
	output logic [`TLB_SET_W-1:0]  wr_set_o,
	output logic [`TLB_ASSOC-1:0]  wr_way_o,
	output logic                   wr_v_o,
	output logic                   wr_g_o,
	output logic [2:0]             wr_rwx_o,
	output logic [`TLB_ASID_W-1:0] wr_asid_o,
	output logic [`TLB_TAG_W-1:0]  wr_tag_o,
	output logic [`TLB_PPN_W-1:0]  wr_ppn_o
);

	tlb_pkg::ctrl_state_t  state_q;
	logic [`TLB_SET_W-1:0] sweep_cnt;
	tlb_pkg::way_idx_t     rr_q;
	tlb_pkg::way_idx_t     way_sel;
	logic [`TLB_ASSOC-1:0] way_oh;

	assign rdy_o = (state_q == tlb_pkg::ST_RUN);

	// target way, named or from the round-robin counter
	always_comb begin
		way_sel = wr_rr_i ? rr_q : wr_way_i;
		way_oh  = '0;
		way_oh[way_sel] = 1'b1;
	end

	// ==============================
	// control state
	// ==============================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state_q   <= tlb_pkg::ST_SWEEP;
			sweep_cnt <= '0;
			rr_q      <= '0;
			wr_en_o   <= 1'b0;
			wr_way_o  <= '0;
		end else begin
			case (state_q)
				tlb_pkg::ST_SWEEP: begin
					// one set per cycle, all ways at once
					wr_en_o   <= 1'b1;
					wr_way_o  <= '1;
					sweep_cnt <= sweep_cnt + 1'b1;
					if (sweep_cnt == `TLB_SETS-1)
						state_q <= tlb_pkg::ST_RUN;
				end
				tlb_pkg::ST_RUN: begin
					wr_en_o  <= wr_i;
					wr_way_o <= way_oh;
					// counter moves only on writes that used it
					if (wr_i && wr_rr_i) begin
						if (rr_q == tlb_pkg::way_idx_t'(`TLB_ASSOC-1))
							rr_q <= '0;
						else
							rr_q <= rr_q + 1'b1;
					end
				end
				default: state_q <= tlb_pkg::ST_SWEEP;
			endcase
		end
	end

	// ==============================
	// write payload
	// ==============================
	// sweep sends an all-zero entry, so v is clear
	always_ff @(posedge clk_g) begin
		if (state_q == tlb_pkg::ST_SWEEP) begin
			wr_set_o  <= sweep_cnt;
			wr_v_o    <= 1'b0;
			wr_g_o    <= 1'b0;
			wr_rwx_o  <= '0;
			wr_asid_o <= '0;
			wr_tag_o  <= '0;
			wr_ppn_o  <= '0;
		end else if (wr_i) begin
			wr_set_o  <= wr_set_i;
			wr_v_o    <= wr_v_i;
			wr_g_o    <= wr_g_i;
			wr_rwx_o  <= wr_rwx_i;
			wr_asid_o <= wr_asid_i;
			wr_tag_o  <= wr_tag_i;
			wr_ppn_o  <= wr_ppn_i;
		end
	end

endmodule

//--- design/tlb_way.sv
// tlb way
// one way of the tlb: entry memory, tag and asid compare, dirty bit write-back
// lookups read on one port, software and dirty writes share the other

`timescale 1ns/10ps

`include "tlb_params.svh"

module tlb_way (
	input  logic                   clk_g,
	input  logic                   rst_i,
	// write port, common to all ways
	input  logic                   wr_en_i,
	input  logic                   wr_sel_i,
	input  logic [`TLB_SET_W-1:0]  wr_set_i,
	input  logic                   wr_v_i,
	input  logic                   wr_g_i,
	input  logic [2:0]             wr_rwx_i,
	input  logic [`TLB_ASID_W-1:0] wr_asid_i,
	input  logic [`TLB_TAG_W-1:0]  wr_tag_i,
	input  logic [`TLB_PPN_W-1:0]  wr_ppn_i,
	// lookup request
	input  logic                   xlat_i,
	input  logic [`TLB_ADR_W-1:0]  vadr_i,
	input  logic [`TLB_ASID_W-1:0] asid_i,
	input  logic                   we_i,
	// compare result, valid in the cycle after the request edge
	output logic                   hit_o,
	output logic [`TLB_PPN_W-1:0]  ppn_o,
	output logic [2:0]             rwx_o,
	output logic                   m_o
);

	tlb_pkg::tlb_entry_t mem [0:`TLB_SETS-1];
	tlb_pkg::tlb_entry_t rd_q;
	tlb_pkg::tlb_entry_t wr_ent;

	logic                   xlat_d;
	logic                   we_d;
	logic [`TLB_SET_W-1:0]  set_d;
	logic [`TLB_TAG_W-1:0]  tag_d;
	logic [`TLB_ASID_W-1:0] asid_d;
	logic                   sw_wr;
	logic                   dirty_wr;

	// ==============================
	// lookup side
	// ==============================
	// memory read and request fields share the one cycle of latency
	always_ff @(posedge clk_g) begin
		if (xlat_i) begin
			rd_q   <= mem[vadr_i[`TLB_OFS_W +: `TLB_SET_W]];
			set_d  <= vadr_i[`TLB_OFS_W +: `TLB_SET_W];
			tag_d  <= vadr_i[`TLB_ADR_W-1 -: `TLB_TAG_W];
			asid_d <= asid_i;
			we_d   <= we_i;
		end
	end

	// request valid, cleared so no stale hit leaves reset
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			xlat_d <= 1'b0;
		else
			xlat_d <= xlat_i;
	end

	// global entries match any asid
	assign hit_o = xlat_d && rd_q.v && (rd_q.tag == tag_d) &&
		(rd_q.g || (rd_q.asid == asid_d));
	assign ppn_o = rd_q.ppn;
	assign rwx_o = rd_q.rwx;
	assign m_o   = rd_q.m;

	// ==============================
	// write side
	// ==============================
	assign sw_wr    = wr_en_i && wr_sel_i;
	assign dirty_wr = hit_o && we_d;

	// fresh installs start clean
	assign wr_ent = '{v: wr_v_i, g: wr_g_i, m: 1'b0, rwx: wr_rwx_i,
		asid: wr_asid_i, tag: wr_tag_i, ppn: wr_ppn_i};

	// software write owns the port, a colliding dirty update is lost
	always_ff @(posedge clk_g) begin
		if (sw_wr)
			mem[wr_set_i] <= wr_ent;
		else if (dirty_wr)
			mem[set_d] <= '{v: rd_q.v, g: rd_q.g, m: 1'b1, rwx: rd_q.rwx,
				asid: rd_q.asid, tag: rd_q.tag, ppn: rd_q.ppn};
	end

endmodule

//--- src.f
+incdir+design
design/tlb_pkg.sv
design/tlb_way.sv
design/tlb_update_ctrl.sv
design/tlb_hit_merge.sv
design/tlb_top.sv
verification/tlb_checker.sv
verification/tlb_tb.sv

//--- verification/tlb_checker.sv
// tlb checker
// bound to the tlb top level: result latency, hit and miss exclusivity,
// single hitting way, ready behaviour and the sweep broadcast

`timescale 1ns/10ps

`include "tlb_params.svh"

module tlb_checker (
	input logic                   clk_g,
	input logic                   rst_i,
	input logic                   xlat_i,
	input logic                   rdy_i,
	input logic                   valid_i,
	input logic                   hit_i,
	input logic                   miss_i,
	input logic                   fault_i,
	input logic [`TLB_ASSOC-1:0]  way_hit_i,
	input tlb_pkg::ctrl_state_t   state_i,
	// controller broadcast
	input logic                   wr_en_i,
	input logic [`TLB_ASSOC-1:0]  wr_way_i,
	input logic                   wr_v_i,
	input logic                   wr_g_i,
	input logic [2:0]             wr_rwx_i,
	input logic [`TLB_ASID_W-1:0] wr_asid_i,
	input logic [`TLB_TAG_W-1:0]  wr_tag_i,
	input logic [`TLB_PPN_W-1:0]  wr_ppn_i
);

	int                  fail_cnt;
	tlb_pkg::tlb_entry_t bcast;

	initial fail_cnt = 0;

	// broadcast entry, fresh installs carry m clear
	assign bcast = {wr_v_i, wr_g_i, 1'b0, wr_rwx_i, wr_asid_i, wr_tag_i, wr_ppn_i};

	// ==============================
	// result timing
	// ==============================
	a_latency: assert property (@(posedge clk_g) disable iff (rst_i)
		valid_i == $past(xlat_i, 2))
		else begin $error("valid does not follow the request by two cycles"); fail_cnt++; end

	a_exclusive: assert property (@(posedge clk_g) disable iff (rst_i) !(hit_i && miss_i))
		else begin $error("hit and miss at once"); fail_cnt++; end

	a_with_valid: assert property (@(posedge clk_g) disable iff (rst_i)
		(hit_i || miss_i) == valid_i)
		else begin $error("hit or miss out of step with valid"); fail_cnt++; end

	a_one_way: assert property (@(posedge clk_g) disable iff (rst_i) $onehot0(way_hit_i))
		else begin $error("more than one way hits"); fail_cnt++; end

	// a fault always comes with a hit
	a_fault_hit: assert property (@(posedge clk_g) disable iff (rst_i) fault_i |-> hit_i)
		else begin $error("fault without a hit"); fail_cnt++; end

	// ==============================
	// ready and sweep
	// ==============================
	// each sweep cycle out of reset is followed by a write to all ways
	a_sweep_all: assert property (@(posedge clk_g) disable iff (rst_i)
		(!rst_i && (state_i == tlb_pkg::ST_SWEEP)) |=> (wr_en_i && (&wr_way_i)))
		else begin $error("sweep did not write all ways"); fail_cnt++; end

	a_rdy_hold: assert property (@(posedge clk_g) disable iff (rst_i) rdy_i |=> rdy_i)
		else begin $error("ready fell after the sweep"); fail_cnt++; end

	// an all-ways write only comes from the sweep
	a_sweep_zero: assert property (@(posedge clk_g) disable iff (rst_i)
		(wr_en_i && (&wr_way_i)) |-> (bcast == '0))
		else begin $error("sweep wrote a non-empty entry"); fail_cnt++; end

endmodule

//--- verification/tlb_tb.sv
// tlb testbench
// runs the reset sweep, named and round-robin installs, asid and global
// matching, rights faults, the dirty update and back-to-back random lookups
// every result is predicted by a reference model of the entry arrays

`timescale 1ns/10ps

`include "tlb_params.svh"

module tlb_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 2;
	localparam int NUM_TESTS    = 128;
	localparam int CYC_PER_TEST = 10;
	localparam int WATCHDOG_NS  =
		(RESET_CYCLES + `TLB_SETS + NUM_TESTS * CYC_PER_TEST) * CLK_PERIOD;

	// expected lookup result
	typedef struct packed {
		logic                  hit;
		logic                  fault;
		tlb_pkg::way_idx_t     way;
		logic [3:0]            acr;
		logic [`TLB_ADR_W-1:0] padr;
	} result_t;

	logic                   clk_g;
	logic                   rst_i;
	logic                   xlat_i;
	logic [`TLB_ADR_W-1:0]  vadr_i;
	logic [`TLB_ASID_W-1:0] asid_i;
	logic                   we_i;
	logic                   wr_i;
	logic                   wr_rr_i;
	tlb_pkg::way_idx_t      wr_way_i;
	logic [`TLB_SET_W-1:0]  wr_set_i;
	logic                   wr_v_i;
	logic                   wr_g_i;
	logic [2:0]             wr_rwx_i;
	logic [`TLB_ASID_W-1:0] wr_asid_i;
	logic [`TLB_TAG_W-1:0]  wr_tag_i;
	logic [`TLB_PPN_W-1:0]  wr_ppn_i;
	logic                   rdy_o;
	logic                   valid_o;
	logic                   hit_o;
	logic                   miss_o;
	tlb_pkg::way_idx_t      hit_way_o;
	logic [`TLB_ADR_W-1:0]  padr_o;
	logic [3:0]             acr_o;
	logic                   fault_o;

	// reference model, one entry per way and set
	tlb_pkg::tlb_entry_t    model [`TLB_ASSOC][`TLB_SETS];
	result_t                exp_q [$];
	logic [`TLB_ADR_W-1:0]  known_adr [$];
	logic [`TLB_ASID_W-1:0] known_asid [$];
	logic [31:0]            rng_state;
	int                     rr_count;

	tlb_top UUT (.*);

	bind tlb_top tlb_checker u_chk (
		.clk_g, .rst_i, .xlat_i, .rdy_i(rdy_o), .valid_i(valid_o), .hit_i(hit_o),
		.miss_i(miss_o), .fault_i(fault_o), .way_hit_i(way_hit),
		.state_i(u_ctrl.state_q), .wr_en_i(wr_en), .wr_way_i(wr_way), .wr_v_i(wr_v),
		.wr_g_i(wr_g), .wr_rwx_i(wr_rwx), .wr_asid_i(wr_asid), .wr_tag_i(wr_tag),
		.wr_ppn_i(wr_ppn)
	);

	always #(CLK_PERIOD/2) clk_g = ~clk_g;

	// ==============================
	// helpers
	// ==============================
	task automatic report_error(input string msg);
		$display("[ERROR] t=%0t %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// xorshift32
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// first way, counted from 0, whose valid entry matches tag and asid
	function automatic result_t predict(input logic [31:0] vadr, input logic [7:0] asid,
		input logic we);
		result_t             r;
		tlb_pkg::tlb_entry_t e;
		r = '0;
		for (int w = 0; w < `TLB_ASSOC && !r.hit; w++) begin
			e = model[w][vadr[16:12]];
			if (e.v && e.tag == vadr[31:17] && (e.g || e.asid == asid)) begin
				r.hit   = 1'b1;
				r.way   = tlb_pkg::way_idx_t'(w);
				r.padr  = {e.ppn, vadr[11:0]};
				r.acr   = {e.m, e.rwx};
				r.fault = we ? !e.rwx[1] : !e.rwx[2];
			end
		end
		return r;
	endfunction

	// another way already holds this tag in the same set
	function automatic logic conflicts(input tlb_pkg::way_idx_t way, input logic [31:0] vadr);
		logic found;
		found = 1'b0;
		for (int w = 0; w < `TLB_ASSOC; w++)
			if (w != way && model[w][vadr[16:12]].v && model[w][vadr[16:12]].tag == vadr[31:17])
				found = 1'b1;
		return found;
	endfunction

	// one software write, then a gap so the next lookup sees it
	task automatic install(input tlb_pkg::way_idx_t way, input logic rr, input logic [31:0] vadr,
		input logic [7:0] asid, input logic g, input logic [2:0] rwx, input logic [19:0] ppn);
		int target;
		target = rr ? (rr_count % `TLB_ASSOC) : int'(way);
		if (rr)
			rr_count++;
		model[target][vadr[16:12]].v    = 1'b1;
		model[target][vadr[16:12]].g    = g;
		model[target][vadr[16:12]].m    = 1'b0;
		model[target][vadr[16:12]].rwx  = rwx;
		model[target][vadr[16:12]].asid = asid;
		model[target][vadr[16:12]].tag  = vadr[31:17];
		model[target][vadr[16:12]].ppn  = ppn;
		@(posedge clk_g);
		wr_i      <= 1'b1;
		wr_rr_i   <= rr;
		wr_way_i  <= way;
		wr_set_i  <= vadr[16:12];
		wr_v_i    <= 1'b1;
		wr_g_i    <= g;
		wr_rwx_i  <= rwx;
		wr_asid_i <= asid;
		wr_tag_i  <= vadr[31:17];
		wr_ppn_i  <= ppn;
		@(posedge clk_g);
		wr_i <= 1'b0;
		@(posedge clk_g);
	endtask

	// request one lookup on the next edge, a write hit marks the model dirty
	task automatic lookup(input logic [31:0] vadr, input logic [7:0] asid, input logic we);
		result_t r;
		r = predict(vadr, asid, we);
		exp_q.push_back(r);
		if (we && r.hit)
			model[r.way][vadr[16:12]].m = 1'b1;
		@(posedge clk_g);
		xlat_i <= 1'b1;
		vadr_i <= vadr;
		asid_i <= asid;
		we_i   <= we;
	endtask

	// stop requesting and wait until every result came back
	task automatic finish_lookups();
		@(posedge clk_g);
		xlat_i <= 1'b0;
		we_i   <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge clk_g);
	endtask

	// ==============================
	// result compare
	// ==============================
	always @(negedge clk_g) begin : compare_result
		result_t want;
		if (!rst_i && valid_o) begin
			assert (exp_q.size() != 0) else report_error("result with no lookup pending");
			want = exp_q.pop_front();
			assert (hit_o == want.hit && miss_o == !want.hit)
				else report_error($sformatf("hit %b miss %b, expected hit %b", hit_o, miss_o,
					want.hit));
			assert (fault_o == want.fault)
				else report_error($sformatf("fault %b, expected %b", fault_o, want.fault));
			if (want.hit) begin
				assert (hit_way_o == want.way)
					else report_error($sformatf("way %0d, expected %0d", hit_way_o, want.way));
				assert (padr_o == want.padr)
					else report_error($sformatf("padr %h, expected %h", padr_o, want.padr));
				assert (acr_o == want.acr)
					else report_error($sformatf("acr %b, expected %b", acr_o, want.acr));
			end
		end
	end

	// bound assertions count their failures
	always @(negedge clk_g)
		if (UUT.u_chk.fail_cnt != 0)
			report_error("bound checker assertion failed");

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, tests did not complete", $time);
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	// ==============================
	// stimulus
	// ==============================
	initial begin : stimulus
		logic [31:0]        rnd;
		logic [31:0]        rnd2;
		logic [31:0]        adr;
		tlb_pkg::way_idx_t  way;
		int                 idx;
		int                 low_cycles;
		rng_state = 32'd93;
		rr_count  = 0;
		clk_g     = 1'b0;
		rst_i     = 1'b1;
		xlat_i    = 1'b0;
		vadr_i    = '0;
		asid_i    = '0;
		we_i      = 1'b0;
		wr_i      = 1'b0;
		wr_rr_i   = 1'b0;
		wr_way_i  = '0;
		wr_set_i  = '0;
		wr_v_i    = 1'b0;
		wr_g_i    = 1'b0;
		wr_rwx_i  = '0;
		wr_asid_i = '0;
		wr_tag_i  = '0;
		wr_ppn_i  = '0;
		for (int w = 0; w < `TLB_ASSOC; w++)
			for (int s = 0; s < `TLB_SETS; s++)
				model[w][s] = '0;

		// reset, outputs low while it is held
		repeat (RESET_CYCLES - 1) @(posedge clk_g);
		@(negedge clk_g);
		assert (!rdy_o && !valid_o && !hit_o && !miss_o && !fault_o)
			else report_error("outputs not low during reset");
		@(posedge clk_g);
		rst_i <= 1'b0;

		// sweep keeps ready low for one cycle per set
		low_cycles = 0;
		@(negedge clk_g);
		while (!rdy_o) begin
			low_cycles++;
			@(negedge clk_g);
		end
		assert (low_cycles == `TLB_SETS)
			else report_error($sformatf("ready low for %0d cycles", low_cycles));
		repeat (4) lookup(next_random(), 8'h11, 1'b0);
		finish_lookups();

		// named way install
		rnd = next_random();
		install(2'd2, 1'b0, {15'h0a5c, 5'd3, 12'h000}, 8'h11, 1'b0, 3'b110, rnd[19:0]);
		lookup({15'h0a5c, 5'd3, 12'h7e4}, 8'h11, 1'b0);
		finish_lookups();

		// asid mismatch misses, global entry matches any asid
		install(2'd1, 1'b0, {15'h3001, 5'd7, 12'h000}, 8'h22, 1'b0, 3'b101, 20'habcde);
		install(2'd3, 1'b0, {15'h3002, 5'd7, 12'h000}, 8'h44, 1'b1, 3'b111, 20'h12345);
		lookup({15'h3001, 5'd7, 12'h010}, 8'h33, 1'b0);
		lookup({15'h3001, 5'd7, 12'h020}, 8'h22, 1'b0);
		lookup({15'h3002, 5'd7, 12'h030}, 8'h55, 1'b0);
		finish_lookups();

		// round robin fills ways 0 to 3, then wraps
		for (int i = 0; i < 5; i++) begin
			rnd = next_random();
			install(2'd0, 1'b1, {15'h1100 + 15'(i), 5'd10 + 5'(i), 12'h000}, 8'h11, 1'b0,
				3'b110, rnd[19:0]);
		end
		for (int i = 0; i < 5; i++)
			lookup({15'h1100 + 15'(i), 5'd10 + 5'(i), 12'h444}, 8'h11, 1'b0);
		finish_lookups();

		// write without w faults, a write hit leaves the entry dirty
		install(2'd0, 1'b0, {15'h2200, 5'd20, 12'h000}, 8'h11, 1'b0, 3'b101, 20'h0f0f0);
		install(2'd1, 1'b0, {15'h2201, 5'd21, 12'h000}, 8'h11, 1'b0, 3'b110, 20'h55aa5);
		lookup({15'h2200, 5'd20, 12'h100}, 8'h11, 1'b1);
		finish_lookups();
		lookup({15'h2201, 5'd21, 12'h200}, 8'h11, 1'b1);
		finish_lookups();
		lookup({15'h2201, 5'd21, 12'h204}, 8'h11, 1'b0);
		finish_lookups();

		// random installs, skipping any that would match twice
		for (int i = 0; i < 16; i++) begin
			rnd  = next_random();
			rnd2 = next_random();
			adr  = {rnd[31:12], 12'h000};
			way  = rnd[1:0];
			if (!conflicts(way, adr)) begin
				install(way, 1'b0, adr, rnd2[7:0], rnd2[8] & rnd2[9], rnd2[12:10], rnd2[31:12]);
				known_adr.push_back(adr);
				known_asid.push_back(rnd2[7:0]);
			end
		end

		// back-to-back reads, half aimed at installed pages
		for (int i = 0; i < 64; i++) begin
			rnd = next_random();
			if (rnd[0] && known_adr.size() != 0) begin
				idx = int'(rnd[31:8] % known_adr.size());
				lookup({known_adr[idx][31:12], rnd[19:8]},
					rnd[1] ? known_asid[idx] : rnd[27:20], 1'b0);
			end else begin
				lookup(next_random(), rnd[27:20], 1'b0);
			end
		end
		finish_lookups();

		repeat (4) @(posedge clk_g);
		if (UUT.u_chk.fail_cnt == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			report_error("bound checker assertion failed");
		end
	end

endmodule
